//--- mem_pkg.sv
package mem_pkg;

    // one bank per ray-tracer port
    localparam int num_regions = 4;

    // 128-bit words, word addressed
    localparam int data_w = 128;
    localparam int addr_w = 32;

    // 64 words per region
    localparam int offset_w = 6;
    localparam int region_words = 64;

    // bits that pick a word inside a region
    localparam logic [addr_w-1:0] offset_mask = {
        {(addr_w - offset_w){1'b0}},
        {offset_w{1'b1}}
    };

    // region bases, 1 MiB apart
    localparam logic [addr_w-1:0] region_base [num_regions] = '{
        32'h0000_0000,
        32'h0010_0000,
        32'h0020_0000,
        32'h0030_0000
    };

    // one data word
    typedef logic [data_w-1:0] mem_word_t;

    // address word, seen flat or split into fields
    typedef union packed {
        logic [addr_w-1:0] raw;
        struct packed {
            // must be zero
            logic [9:0]          pad_hi;
            logic [1:0]          region;
            // must be zero
            logic [13:0]         pad_mid;
            logic [offset_w-1:0] offset;
        } fields;
    } mem_addr_u;

    // legal when both pad fields are clear
    function automatic logic addr_legal(mem_addr_u a);
        return (a.fields.pad_hi == '0) && (a.fields.pad_mid == '0);
    endfunction

endpackage

//--- mem_port_if.sv
interface mem_port_if;
    import mem_pkg::*;

    // request side, from the port adapter
    logic                req;
    logic                we;
    logic [offset_w-1:0] offset;
    mem_word_t           wdata;

    // response side, from the bank
    mem_word_t           rdata;
    // one cycle after req
    logic                ack;

    modport requester (
        output req,
        output we,
        output offset,
        output wdata,
        input  rdata,
        input  ack
    );

    modport responder (
        input  req,
        input  we,
        input  offset,
        input  wdata,
        output rdata,
        output ack
    );

endinterface

//--- mem_rt_port.sv
module mem_rt_port (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [1:0]                   region_id,
    input  logic                         we,
    input  logic                         re,
    input  logic [mem_pkg::addr_w-1:0]   addr,
    input  mem_pkg::mem_word_t           wdata,
    output mem_pkg::mem_word_t           rdata,
    output logic                         rdy,
    output logic                         err,
    mem_port_if.requester                bank
);
    import mem_pkg::*;

    mem_addr_u           a;
    logic                strobe;
    logic                hit;
    logic                req_q;
    logic                miss_q;
    logic                err_q;
    logic                we_q;
    logic [offset_w-1:0] offset_q;
    mem_word_t           wdata_q;

    assign a = addr;
    // we and re together count as a write
    assign strobe = we | re;
    // pads clear and region field matches this port
    assign hit = (a.raw & ~offset_mask) == region_base[region_id];

    // strobe registered at the edge it is seen
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q  <= 1'b0;
            miss_q <= 1'b0;
            err_q  <= 1'b0;
        end else begin
            req_q  <= strobe & hit;
            miss_q <= strobe & ~hit;
            // extra stage so the error lines up with a bank ack
            err_q  <= miss_q;
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (strobe) begin
            we_q     <= we;
            offset_q <= a.fields.offset;
            wdata_q  <= wdata;
        end
    end

    assign bank.req    = req_q;
    assign bank.we     = we_q;
    assign bank.offset = offset_q;
    assign bank.wdata  = wdata_q;

    // ack and error never overlap, one request per cycle
    assign rdy   = bank.ack | err_q;
    assign err   = err_q;
    assign rdata = bank.rdata;

endmodule

//--- mem_bank.sv
module mem_bank (
    input  logic                           clk,
    mem_port_if.responder                  rt,
    input  logic                           mc_rd,
    input  logic [mem_pkg::offset_w-1:0]   mc_offset,
    output logic                           mc_grant,
    output mem_pkg::mem_word_t             mc_rdata,
    input  logic                           rst_n
);
    import mem_pkg::*;

    // storage for one region
    mem_word_t           mem [region_words];
    mem_word_t           rd_q;
    logic                mc_take;
    logic                rt_rd;
    logic [offset_w-1:0] rd_offset;

    // ray-tracer side always wins the cycle
    assign rt_rd = rt.req & ~rt.we;

    // mc read only on an idle cycle
    // and not while its previous grant is still out
    assign mc_take = mc_rd & ~rt.req & ~mc_grant;

    // single read port, shared
    assign rd_offset = rt.req ? rt.offset : mc_offset;

    always_ff @(posedge clk) begin
        if (rt.req && rt.we) begin
            mem[rt.offset] <= rt.wdata;
        end
        // registered read data, held between reads
        if (rt_rd || mc_take) begin
            rd_q <= mem[rd_offset];
        end
    end

    // one-cycle response pulses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rt.ack   <= 1'b0;
            mc_grant <= 1'b0;
        end else begin
            // every req answered next cycle, no stall
            rt.ack   <= rt.req;
            mc_grant <= mc_take;
        end
    end

    // both sides see the same register
    // valid for whichever one its pulse belongs to
    assign rt.rdata = rd_q;
    assign mc_rdata = rd_q;

endmodule

//--- mem_mc_read.sv
module mem_mc_read (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          re,
    input  logic [mem_pkg::addr_w-1:0]                    addr,
    output logic [mem_pkg::num_regions-1:0]               bank_rd,
    output logic [mem_pkg::offset_w-1:0]                  bank_offset,
    input  logic [mem_pkg::num_regions-1:0]               bank_grant,
    input  mem_pkg::mem_word_t [mem_pkg::num_regions-1:0] bank_rdata,
    output mem_pkg::mem_word_t                            rdata,
    output logic                                          rdy,
    output logic                                          err
);
    import mem_pkg::*;

    mem_addr_u           a;
    logic                pending;
    logic                bad_q;
    logic [1:0]          sel_q;
    logic [offset_w-1:0] offset_q;
    logic                granted;

    assign a = addr;
    // grant from the bank that was asked
    assign granted = bank_grant[sel_q];

    // pending until the bank grants, then done pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
            bad_q   <= 1'b0;
            sel_q   <= '0;
            rdy     <= 1'b0;
            err     <= 1'b0;
        end else begin
            rdy <= 1'b0;
            err <= 1'b0;
            if (!pending) begin
                // new read only when idle, ignored otherwise
                if (re) begin
                    pending <= 1'b1;
                    bad_q   <= ~addr_legal(a);
                    sel_q   <= a.fields.region;
                end
            end else if (bad_q) begin
                // illegal address, no bank access
                pending <= 1'b0;
                rdy     <= 1'b1;
                err     <= 1'b1;
            end else if (granted) begin
                pending <= 1'b0;
                rdy     <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!pending && re) begin
            offset_q <= a.fields.offset;
        end
        if (pending && !bad_q && granted) begin
            rdata <= bank_rdata[sel_q];
        end
    end

    // hold the strobe on the target bank until it grants
    always_comb begin
        bank_rd        = '0;
        bank_rd[sel_q] = pending & ~bad_q;
    end

    assign bank_offset = offset_q;

endmodule

//--- mem_main.sv
module mem_main (
    input  logic                                                clk,
    input  logic                                                rst_n,

    // ray-tracer ports, region i in slice i
    input  logic [mem_pkg::num_regions-1:0]                     rt_we,
    input  logic [mem_pkg::num_regions-1:0]                     rt_re,
    input  logic [mem_pkg::num_regions-1:0][mem_pkg::addr_w-1:0] rt_addr,
    input  mem_pkg::mem_word_t [mem_pkg::num_regions-1:0]       rt_wdata,
    output mem_pkg::mem_word_t [mem_pkg::num_regions-1:0]       rt_rdata,
    output logic [mem_pkg::num_regions-1:0]                     rt_rdy,
    output logic [mem_pkg::num_regions-1:0]                     rt_err,

    // memory-controller read port
    input  logic                                                mc_re,
    input  logic [mem_pkg::addr_w-1:0]                          mc_addr,
    output mem_pkg::mem_word_t                                  mc_rdata,
    output logic                                                mc_rdy,
    output logic                                                mc_err
);
    import mem_pkg::*;

    // mc reader to banks
    logic [num_regions-1:0]            mc_bank_rd;
    logic [offset_w-1:0]               mc_bank_offset;
    logic [num_regions-1:0]            mc_bank_grant;
    mem_word_t [num_regions-1:0]       mc_bank_rdata;

    for (genvar i = 0; i < num_regions; i++) begin : g_region
        // adapter to bank link
        mem_port_if bank_if ();

        mem_rt_port u_port (
            .clk       (clk),
            .rst_n     (rst_n),
            .region_id (2'(i)),
            .we        (rt_we[i]),
            .re        (rt_re[i]),
            .addr      (rt_addr[i]),
            .wdata     (rt_wdata[i]),
            .rdata     (rt_rdata[i]),
            .rdy       (rt_rdy[i]),
            .err       (rt_err[i]),
            .bank      (bank_if)
        );

        mem_bank u_bank (
            .clk       (clk),
            .rt        (bank_if),
            .mc_rd     (mc_bank_rd[i]),
            .mc_offset (mc_bank_offset),
            .mc_grant  (mc_bank_grant[i]),
            .mc_rdata  (mc_bank_rdata[i]),
            .rst_n     (rst_n)
        );
    end

    // one shared reader across all regions
    mem_mc_read u_mc (
        .clk         (clk),
        .rst_n       (rst_n),
        .re          (mc_re),
        .addr        (mc_addr),
        .bank_rd     (mc_bank_rd),
        .bank_offset (mc_bank_offset),
        .bank_grant  (mc_bank_grant),
        .bank_rdata  (mc_bank_rdata),
        .rdata       (mc_rdata),
        .rdy         (mc_rdy),
        .err         (mc_err)
    );

endmodule

//--- tb_mem_main.sv
module tb_mem_main;
    timeunit 1ns;
    timeprecision 1ps;
    import mem_pkg::*;

    logic clk = 1'b0;
    logic rst_n;

    // ray-tracer side with one slice per port
    logic [num_regions-1:0]             rt_we;
    logic [num_regions-1:0]             rt_re;
    logic [num_regions-1:0][addr_w-1:0] rt_addr;
    mem_word_t [num_regions-1:0]        rt_wdata;
    mem_word_t [num_regions-1:0]        rt_rdata;
    logic [num_regions-1:0]             rt_rdy;
    logic [num_regions-1:0]             rt_err;

    // memory-controller side
    logic                               mc_re;
    logic [addr_w-1:0]                  mc_addr;
    mem_word_t                          mc_rdata;
    logic                               mc_rdy;
    logic                               mc_err;

    // test table with one entry per op line
    logic [7:0]  t_op [$];
    logic [1:0]  t_port [$];
    logic [31:0] t_addr [$];
    mem_word_t   t_data [$];
    mem_word_t   t_exp [$];
    logic        t_err [$];

    int cycles = 0;
    int limit = 0;

    mem_main uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .rt_we    (rt_we),
        .rt_re    (rt_re),
        .rt_addr  (rt_addr),
        .rt_wdata (rt_wdata),
        .rt_rdata (rt_rdata),
        .rt_rdy   (rt_rdy),
        .rt_err   (rt_err),
        .mc_re    (mc_re),
        .mc_addr  (mc_addr),
        .mc_rdata (mc_rdata),
        .mc_rdy   (mc_rdy),
        .mc_err   (mc_err)
    );

    // 100 ns period
    always #50 clk = ~clk;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input mem_word_t got, input mem_word_t expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED %s got %0h expected %0h",
                                        name, got, expected));
        end
    endtask

    // run bound grows with the number of ops
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            stop_with_failure($sformatf("timeout after %0d cycles", cycles));
        end
    end

    // parse every op line and skip comments and blank lines
    task automatic load_tests();
        int         fd;
        int         code;
        int         n;
        int         port;
        int         err;
        string      line;
        logic [7:0] op;
        logic [31:0] addr;
        mem_word_t  data;
        mem_word_t  exp;
        fd = $fopen("mem_tests.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open mem_tests.txt for reading");
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code != 0 && line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%c %d %h %h %h %d", op, port, addr, data, exp, err);
                if (n != 6 || port < 0 || port > 3 || !(op inside {"w", "r", "m", "p"})) begin
                    stop_with_failure({"malformed line in mem_tests.txt: ", line});
                end
                t_op.push_back(op);
                t_port.push_back(2'(port));
                t_addr.push_back(addr);
                t_data.push_back(data);
                t_exp.push_back(exp);
                t_err.push_back(err != 0);
            end
        end
        $fclose(fd);
    endtask

    // single strobe with rdy two edges after the DUT sees it
    task automatic rt_access(input logic [1:0] port, input logic wr, input logic [31:0] addr,
                             input mem_word_t data, input mem_word_t exp, input logic exp_err);
        @(posedge clk);
        rt_we[port]    <= wr;
        rt_re[port]    <= ~wr;
        rt_addr[port]  <= addr;
        rt_wdata[port] <= data;
        // strobe registered at edge N
        @(posedge clk);
        rt_we[port] <= 1'b0;
        rt_re[port] <= 1'b0;
        @(negedge clk);
        check_value("rt_rdy", 128'(rt_rdy[port]), 128'(0));
        @(negedge clk);
        check_value("rt_rdy", 128'(rt_rdy[port]), 128'(1));
        check_value("rt_err", 128'(rt_err[port]), 128'(exp_err));
        if (!wr && !exp_err) begin
            check_value("rt_rdata", rt_rdata[port], exp);
        end
        @(negedge clk);
        check_value("rt_rdy", 128'(rt_rdy[port]), 128'(0));
    endtask

    // writes addr then addr+1 with inverted data so two are in flight
    task automatic write_pair(input logic [1:0] port, input logic [31:0] addr,
                              input mem_word_t data, input logic exp_err);
        @(posedge clk);
        rt_we[port]    <= 1'b1;
        rt_re[port]    <= 1'b0;
        rt_addr[port]  <= addr;
        rt_wdata[port] <= data;
        // first write registered here
        @(posedge clk);
        rt_addr[port]  <= addr + 32'd1;
        rt_wdata[port] <= ~data;
        // first response not out yet
        @(negedge clk);
        check_value("rt_rdy", 128'(rt_rdy[port]), 128'(0));
        // second write registered here
        @(posedge clk);
        rt_we[port] <= 1'b0;
        // one pulse per write on consecutive cycles
        repeat (2) begin
            @(negedge clk);
            check_value("rt_rdy", 128'(rt_rdy[port]), 128'(1));
            check_value("rt_err", 128'(rt_err[port]), 128'(exp_err));
        end
        @(negedge clk);
        check_value("rt_rdy", 128'(rt_rdy[port]), 128'(0));
    endtask

    // latency varies so wait for mc_rdy
    task automatic mc_read(input logic [31:0] addr, input mem_word_t exp, input logic exp_err);
        @(posedge clk);
        mc_re   <= 1'b1;
        mc_addr <= addr;
        @(posedge clk);
        mc_re <= 1'b0;
        @(negedge clk);
        while (mc_rdy !== 1'b1) begin
            @(negedge clk);
        end
        check_value("mc_err", 128'(mc_err), 128'(exp_err));
        if (!exp_err) begin
            check_value("mc_rdata", mc_rdata, exp);
        end
        @(negedge clk);
        check_value("mc_rdy", 128'(mc_rdy), 128'(0));
    endtask

    initial begin
        int i;
        rst_n    <= 1'b0;
        rt_we    <= '0;
        rt_re    <= '0;
        rt_addr  <= '0;
        rt_wdata <= '0;
        mc_re    <= 1'b0;
        mc_addr  <= '0;
        load_tests();
        limit = t_op.size() * 8 + 50;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        // responses idle before any strobe
        @(negedge clk);
        check_value("rt_rdy", 128'(rt_rdy), 128'(0));
        check_value("rt_err", 128'(rt_err), 128'(0));
        check_value("mc_rdy", 128'(mc_rdy), 128'(0));
        check_value("mc_err", 128'(mc_err), 128'(0));
        i = 0;
        while (i < t_op.size()) begin
            case (t_op[i])
                "w": rt_access(t_port[i], 1'b1, t_addr[i], t_data[i], t_exp[i], t_err[i]);
                "r": rt_access(t_port[i], 1'b0, t_addr[i], t_data[i], t_exp[i], t_err[i]);
                "p": write_pair(t_port[i], t_addr[i], t_data[i], t_err[i]);
                default: begin
                    // mc read followed by a pair starts in the same cycle
                    if (i + 1 < t_op.size() && t_op[i + 1] == "p") begin
                        fork
                            mc_read(t_addr[i], t_exp[i], t_err[i]);
                            write_pair(t_port[i + 1], t_addr[i + 1], t_data[i + 1], t_err[i + 1]);
                        join
                        i = i + 1;
                    end else begin
                        mc_read(t_addr[i], t_exp[i], t_err[i]);
                    end
                end
            endcase
            i = i + 1;
        end
        $display("All checks passed");
        $finish;
    end

endmodule

//--- mem_tests.txt
# op port addr data expected err  (hex addr/data/expected, err 0 or 1)
# w write, r read, m mc read (port unused), p writes addr and addr+1 with ~data; m before p overlap
w 0 00000005 0123456789abcdef0011223344556677 00000000000000000000000000000000 0
r 0 00000005 00000000000000000000000000000000 0123456789abcdef0011223344556677 0
w 1 00100005 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 00000000000000000000000000000000 0
w 2 00200007 2222222233333333444444445555555f 00000000000000000000000000000000 0
w 3 0030003f fedcba98765432100f1e2d3c4b5a6978 00000000000000000000000000000000 0
r 1 00100005 00000000000000000000000000000000 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 0
r 3 0030003f 00000000000000000000000000000000 fedcba98765432100f1e2d3c4b5a6978 0
w 0 00100005 deadbeefdeadbeefdeadbeefdeadbeef 00000000000000000000000000000000 1
r 1 00100005 00000000000000000000000000000000 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 0
w 2 00200047 badc0ffee0ddf00dbadc0ffee0ddf00d 00000000000000000000000000000000 1
r 2 00200007 00000000000000000000000000000000 2222222233333333444444445555555f 0
r 1 00500005 00000000000000000000000000000000 00000000000000000000000000000000 1
p 2 00200010 1000000000000000000000000000000a 00000000000000000000000000000000 0
r 2 00200010 00000000000000000000000000000000 1000000000000000000000000000000a 0
r 2 00200011 00000000000000000000000000000000 effffffffffffffffffffffffffffff5 0
m 0 00000005 00000000000000000000000000000000 0123456789abcdef0011223344556677 0
m 0 0030003f 00000000000000000000000000000000 fedcba98765432100f1e2d3c4b5a6978 0
m 0 00100005 00000000000000000000000000000000 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 0
m 0 00000080 00000000000000000000000000000000 00000000000000000000000000000000 1
m 0 01200007 00000000000000000000000000000000 00000000000000000000000000000000 1
m 0 00200007 00000000000000000000000000000000 2222222233333333444444445555555f 0
p 2 00200020 00000000ffffffff00000000ffffffff 00000000000000000000000000000000 0
r 2 00200020 00000000000000000000000000000000 00000000ffffffff00000000ffffffff 0
r 2 00200021 00000000000000000000000000000000 ffffffff00000000ffffffff00000000 0
p 1 00000004 deadbeefdeadbeefdeadbeefdeadbeef 00000000000000000000000000000000 1
r 0 00000005 00000000000000000000000000000000 0123456789abcdef0011223344556677 0
m 0 00200011 00000000000000000000000000000000 effffffffffffffffffffffffffffff5 0

//--- verilog.f
mem_pkg.sv
mem_port_if.sv
mem_rt_port.sv
mem_bank.sv
mem_mc_read.sv
mem_main.sv
tb_mem_main.sv

//--- run.sh
#!/bin/sh
# build and run the memory testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
    --top-module tb_mem_main -o sim_mem_main
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_mem_main
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
